// File: design/sdram_consts.svh
//**********************************************************
// Address map, bank numbers and slot widths of the SDRAM
// multiplexer, included by the package, the RTL and the bench
//**********************************************************
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// SDRAM word address, write and read widths
`define SDRAM_AW 22
`define SDRAM_DW 16
`define SDRAM_RW 32

// Region base addresses, in SDRAM words
`define SOUND_OFFSET 22'h00_0000
`define ADPCM_OFFSET 22'h01_0000
`define RAM_OFFSET   22'h20_0000
`define VRAM_OFFSET  22'h30_0000
// Graphics sit alone in their bank
`define GFX_OFFSET   22'h00_0000

// Bank per client group
`define BANK_CPU 2'd1
`define BANK_GFX 2'd2
`define BANK_SND 2'd0

// Client address widths
`define ROM_AW   21
`define RAM_AW   17
`define GFX_AW   22
`define SND_AW   16
`define ADPCM_AW 18

// Slot indices, lower index wins arbitration
`define NSLOTS     5
`define SLOT_ROM   0
`define SLOT_RAM   1
`define SLOT_GFX   2
`define SLOT_ADPCM 3
`define SLOT_SND   4

`endif

// File: design/sdram_pkg.sv
//**********************************************************
// Data types shared by the SDRAM slot arbiter, the top level
// and the bench
//**********************************************************
`default_nettype none

`include "sdram_consts.svh"

package sdram_pkg;

    // Halfword and byte views of the data returned by the SDRAM
    typedef logic [`SDRAM_DW-1:0] half_t;
    typedef logic [7:0]           byte_t;
    typedef logic [`SDRAM_RW-1:0] gfx_word_t;

    // One 32-bit read word, decoded per slot width.
    // Lower half and bytes 0/1 belong to the addressed location
    typedef union packed {
        logic [1:0][`SDRAM_DW-1:0] halves;
        logic [3:0][7:0]           bytes;
    } sdram_word_t;

endpackage

`default_nettype wire

// File: design/slot_cache.sv
//**********************************************************
// One-entry cache of a client slot, it answers hits locally
// and holds a request to the arbiter until the fill arrives
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module slot_cache #(
    parameter int AW = 16,
    parameter int DW = 16
) (
    input  wire logic          VB,
    input  wire logic          arst_n,
    // Client side
    input  wire logic          cs,
    input  wire logic [AW-1:0] addr,
    input  wire logic          rnw,
    input  wire logic [DW-1:0] din,
    input  wire logic [1:0]    dsn,
    output logic      [DW-1:0] data,
    output logic               ok,
    // Arbiter side
    output logic               req,
    output logic      [AW-1:0] req_addr,
    input  wire logic          fill,
    input  wire logic [DW-1:0] fill_data
);

    logic          valid;
    logic          done;
    logic          req_rnw;
    logic [AW-1:0] tag;
    logic [DW-1:0] entry;
    logic [DW-1:0] merged;
    logic          tag_match;
    logic          served;
    logic          start;

    assign tag_match = (tag == addr);

    // Reads hit a valid entry, writes only the one just completed
    assign served = tag_match && (rnw ? valid : done);

    // New access only when idle and not in the fill cycle
    assign start = !req && cs && !served && !fill;

    assign data = entry;

    // Write data merged over the cached word, byte lanes active low
    always_comb begin
        merged = entry;
        for (int i = 0; i < DW / 8 && i < 2; i++) begin
            if (!dsn[i]) begin
                merged[i*8 +: 8] = din[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            req     <= 1'b0;
            req_rnw <= 1'b1;
            valid   <= 1'b0;
            done    <= 1'b0;
            ok      <= 1'b0;
        end else begin
            // A dropped cs still takes the fill but keeps ok low
            ok <= cs && (fill ? (addr == req_addr) : served);
            if (fill) begin
                req   <= 1'b0;
                done  <= !req_rnw;
                // Partial write over another address leaves unknown lanes
                valid <= req_rnw || (valid && tag == req_addr) || (dsn == 2'b00);
            end else begin
                if (start) begin
                    req     <= 1'b1;
                    req_rnw <= rnw;
                end
                if (!cs || !tag_match) begin
                    done <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge VB) begin
        if (start) begin
            req_addr <= addr;
        end
        if (fill) begin
            tag   <= req_addr;
            entry <= req_rnw ? fill_data : merged;
        end
    end

endmodule

`default_nettype wire

// File: design/slot_arbiter.sv
//**********************************************************
// Fixed-priority arbiter between the slot caches, issues one
// SDRAM access at a time and steers the read word back
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "sdram_consts.svh"

module slot_arbiter import sdram_pkg::*; (
    input  wire logic                   VB,
    input  wire logic                   arst_n,
    // Slot requests and addresses
    input  wire logic [`NSLOTS-1:0]     req,
    input  wire logic [`ROM_AW-1:0]     rom_addr,
    input  wire logic [`RAM_AW:0]       ram_addr,
    input  wire logic [`GFX_AW-1:0]     gfx_addr,
    input  wire logic [`ADPCM_AW-1:0]   adpcm_addr,
    input  wire logic [`SND_AW-1:0]     snd_addr,
    input  wire logic                   ram_rnw,
    input  wire half_t                  ram_din,
    input  wire logic [1:0]             ram_dsn,
    // Fill towards the winning slot
    output logic      [`NSLOTS-1:0]     fill,
    output half_t                       fill_half,
    output byte_t                       fill_byte,
    output gfx_word_t                   fill_gfx,
    // SDRAM side
    output logic                        sdram_req,
    output logic      [`SDRAM_AW-1:0]   sdram_addr,
    output logic      [1:0]             sdram_bank,
    output logic                        sdram_rnw,
    output logic      [1:0]             sdram_wrmask,
    output half_t                       data_write,
    input  wire logic                   sdram_ack,
    input  wire logic                   data_rdy,
    input  wire sdram_word_t            data_read
);

    localparam int IW = $clog2(`NSLOTS);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

    state_t               state;
    logic [IW-1:0]        pick;
    logic [IW-1:0]        winner;
    logic                 byte_sel;
    logic [`SDRAM_AW-1:0] next_addr;
    logic [`SDRAM_AW-1:0] ram_base;
    logic [1:0]           next_bank;
    logic                 next_rnw;
    logic                 next_lane;
    logic                 launch;
    logic                 rd_done;

    // Lowest pending index wins
    always_comb begin
        pick = '0;
        for (int i = `NSLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick = IW'(i);
            end
        end
    end

    // Top bit of the RAM slot address selects VRAM
    assign ram_base = ram_addr[`RAM_AW] ? `VRAM_OFFSET : `RAM_OFFSET;

    always_comb begin
        next_addr = {{(`SDRAM_AW-`ROM_AW){1'b0}}, rom_addr};
        next_bank = `BANK_CPU;
        next_rnw  = 1'b1;
        next_lane = 1'b0;
        case (pick)
            `SLOT_RAM: begin
                next_addr = ram_base + {{(`SDRAM_AW-`RAM_AW){1'b0}}, ram_addr[`RAM_AW-1:0]};
                next_bank = `BANK_SND;
                next_rnw  = ram_rnw;
            end
            `SLOT_GFX: begin
                next_addr = `GFX_OFFSET + gfx_addr;
                next_bank = `BANK_GFX;
            end
            // Byte clients address 16-bit words, bit 0 picks the lane
            `SLOT_ADPCM: begin
                next_addr = `ADPCM_OFFSET
                          + {{(`SDRAM_AW-`ADPCM_AW+1){1'b0}}, adpcm_addr[`ADPCM_AW-1:1]};
                next_bank = `BANK_SND;
                next_lane = adpcm_addr[0];
            end
            `SLOT_SND: begin
                next_addr = `SOUND_OFFSET
                          + {{(`SDRAM_AW-`SND_AW+1){1'b0}}, snd_addr[`SND_AW-1:1]};
                next_bank = `BANK_SND;
                next_lane = snd_addr[0];
            end
            default: ;
        endcase
    end

    assign launch  = (state == ST_IDLE) && (|req);
    assign rd_done = (state == ST_WAIT) && data_rdy;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        state     <= ST_REQ;
                        sdram_req <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        state     <= ST_WAIT;
                        sdram_req <= 1'b0;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields stay frozen until the next launch
    always_ff @(posedge VB) begin
        if (launch) begin
            winner       <= pick;
            byte_sel     <= next_lane;
            sdram_addr   <= next_addr;
            sdram_bank   <= next_bank;
            sdram_rnw    <= next_rnw;
            sdram_wrmask <= next_rnw ? 2'b00 : ram_dsn;
            data_write   <= ram_din;
        end
    end

    always_comb begin
        for (int i = 0; i < `NSLOTS; i++) begin
            fill[i] = rd_done && (winner == IW'(i));
        end
    end

    assign fill_half = data_read.halves[0];
    assign fill_byte = byte_sel ? data_read.bytes[1] : data_read.bytes[0];
    assign fill_gfx  = data_read;

endmodule

`default_nettype wire

// File: design/sdram_mux_top.sv
//**********************************************************
// SDRAM multiplexer top, five client slots with their caches
// sharing one SDRAM controller port through the arbiter
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_mux_top import sdram_pkg::*; (
    input  wire logic                   VB,
    input  wire logic                   arst_n,
    // Main program ROM
    input  wire logic                   rom_cs,
    input  wire logic [`ROM_AW-1:0]     rom_addr,
    output half_t                       rom_data,
    output logic                        rom_ok,
    // Work RAM and VRAM
    input  wire logic                   ram_sel,
    input  wire logic                   vram_sel,
    input  wire logic [`RAM_AW-1:0]     ram_addr,
    input  wire logic                   ram_rnw,
    input  wire half_t                  ram_din,
    input  wire logic [1:0]             ram_dsn,
    output half_t                       ram_data,
    output logic                        ram_ok,
    // Graphics ROM
    input  wire logic                   gfx_cs,
    input  wire logic [`GFX_AW-1:0]     gfx_addr,
    output gfx_word_t                   gfx_data,
    output logic                        gfx_ok,
    // ADPCM samples
    input  wire logic                   adpcm_cs,
    input  wire logic [`ADPCM_AW-1:0]   adpcm_addr,
    output byte_t                       adpcm_data,
    output logic                        adpcm_ok,
    // Sound program ROM
    input  wire logic                   snd_cs,
    input  wire logic [`SND_AW-1:0]     snd_addr,
    output byte_t                       snd_data,
    output logic                        snd_ok,
    // SDRAM controller
    output logic                        sdram_req,
    output logic      [`SDRAM_AW-1:0]   sdram_addr,
    output logic      [1:0]             sdram_bank,
    output logic                        sdram_rnw,
    output logic      [1:0]             sdram_wrmask,
    output half_t                       data_write,
    input  wire logic                   sdram_ack,
    input  wire logic                   data_rdy,
    input  wire sdram_word_t            data_read
);

    logic [`NSLOTS-1:0]   req;
    logic [`NSLOTS-1:0]   fill;
    logic [`ROM_AW-1:0]   rom_req_addr;
    logic [`RAM_AW:0]     ram_req_addr;
    logic [`GFX_AW-1:0]   gfx_req_addr;
    logic [`ADPCM_AW-1:0] adpcm_req_addr;
    logic [`SND_AW-1:0]   snd_req_addr;
    half_t                fill_half;
    byte_t                fill_byte;
    gfx_word_t            fill_gfx;
    logic                 ram_cs;

    assign ram_cs = ram_sel | vram_sel;

    slot_cache #(.AW(`ROM_AW), .DW(16)) u_rom (
        .VB(VB), .arst_n(arst_n),
        .cs(rom_cs), .addr(rom_addr), .rnw(1'b1), .din(16'd0), .dsn(2'b11),
        .data(rom_data), .ok(rom_ok),
        .req(req[`SLOT_ROM]), .req_addr(rom_req_addr),
        .fill(fill[`SLOT_ROM]), .fill_data(fill_half)
    );

    // VRAM select on top keeps the two regions apart in the cache
    slot_cache #(.AW(`RAM_AW + 1), .DW(16)) u_ram (
        .VB(VB), .arst_n(arst_n),
        .cs(ram_cs), .addr({vram_sel, ram_addr}), .rnw(ram_rnw),
        .din(ram_din), .dsn(ram_dsn),
        .data(ram_data), .ok(ram_ok),
        .req(req[`SLOT_RAM]), .req_addr(ram_req_addr),
        .fill(fill[`SLOT_RAM]), .fill_data(fill_half)
    );

    slot_cache #(.AW(`GFX_AW), .DW(32)) u_gfx (
        .VB(VB), .arst_n(arst_n),
        .cs(gfx_cs), .addr(gfx_addr), .rnw(1'b1), .din(32'd0), .dsn(2'b11),
        .data(gfx_data), .ok(gfx_ok),
        .req(req[`SLOT_GFX]), .req_addr(gfx_req_addr),
        .fill(fill[`SLOT_GFX]), .fill_data(fill_gfx)
    );

    slot_cache #(.AW(`ADPCM_AW), .DW(8)) u_adpcm (
        .VB(VB), .arst_n(arst_n),
        .cs(adpcm_cs), .addr(adpcm_addr), .rnw(1'b1), .din(8'd0), .dsn(2'b11),
        .data(adpcm_data), .ok(adpcm_ok),
        .req(req[`SLOT_ADPCM]), .req_addr(adpcm_req_addr),
        .fill(fill[`SLOT_ADPCM]), .fill_data(fill_byte)
    );

    slot_cache #(.AW(`SND_AW), .DW(8)) u_snd (
        .VB(VB), .arst_n(arst_n),
        .cs(snd_cs), .addr(snd_addr), .rnw(1'b1), .din(8'd0), .dsn(2'b11),
        .data(snd_data), .ok(snd_ok),
        .req(req[`SLOT_SND]), .req_addr(snd_req_addr),
        .fill(fill[`SLOT_SND]), .fill_data(fill_byte)
    );

    slot_arbiter u_arb (
        .VB(VB), .arst_n(arst_n),
        .req(req),
        .rom_addr(rom_req_addr), .ram_addr(ram_req_addr), .gfx_addr(gfx_req_addr),
        .adpcm_addr(adpcm_req_addr), .snd_addr(snd_req_addr),
        .ram_rnw(ram_rnw), .ram_din(ram_din), .ram_dsn(ram_dsn),
        .fill(fill), .fill_half(fill_half), .fill_byte(fill_byte), .fill_gfx(fill_gfx),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_bank(sdram_bank),
        .sdram_rnw(sdram_rnw), .sdram_wrmask(sdram_wrmask), .data_write(data_write),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

endmodule

`default_nettype wire

// File: bench/sdram_model.sv
//**********************************************************
// Behavioral SDRAM for the bench with random ack and read
// delays and pattern contents where nothing has been written
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_model import sdram_pkg::*; (
    input  wire logic                 VB,
    input  wire logic                 arst_n,
    input  wire logic                 sdram_req,
    input  wire logic [`SDRAM_AW-1:0] sdram_addr,
    input  wire logic [1:0]           sdram_bank,
    input  wire logic                 sdram_rnw,
    input  wire logic [1:0]           sdram_wrmask,
    input  wire half_t                data_write,
    output logic                      sdram_ack,
    output logic                      data_rdy,
    output sdram_word_t               data_read
);

    half_t       mem [logic [23:0]];
    logic [31:0] rng = 32'h5cf4;
    logic [1:0]  phase;
    logic [3:0]  cnt;
    logic [23:0] key;
    half_t       old_word;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic half_t pattern_of(input logic [1:0] bank, input logic [21:0] a);
        logic [31:0] h;
        h = {8'd0, bank, a} * 32'h9e37_79b1;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic half_t stored(input logic [23:0] k);
        return mem.exists(k) ? mem[k] : pattern_of(k[23:22], k[21:0]);
    endfunction

    always @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            phase     <= 2'd0;
            cnt       <= 4'd0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            rng = next_random(rng);
            case (phase)
                2'd0: if (sdram_req) begin
                    cnt   <= 4'd1 + 4'(rng[17:16] % 3);
                    phase <= 2'd1;
                end
                2'd1: if (cnt == 4'd1) begin
                    sdram_ack <= 1'b1;
                    key        = {sdram_bank, sdram_addr};
                    // Writes land at ack time and a high mask bit keeps its lane
                    if (!sdram_rnw) begin
                        old_word = stored(key);
                        mem[key] = {sdram_wrmask[1] ? old_word[15:8] : data_write[15:8],
                                    sdram_wrmask[0] ? old_word[7:0] : data_write[7:0]};
                    end
                    cnt   <= 4'd2 + 4'(rng[19:16] % 4);
                    phase <= 2'd2;
                end else cnt <= cnt - 4'd1;
                default: if (cnt == 4'd1) begin
                    data_rdy  <= 1'b1;
                    data_read <= {stored({key[23:22], key[21:0] + 22'd1}), stored(key)};
                    phase     <= 2'd0;
                end else cnt <= cnt - 4'd1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_sdram_mux.sv
//**********************************************************
// Top of the SDRAM multiplexer simulation with five directed
// tests against a behavioral SDRAM
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "sdram_consts.svh"

module tb_sdram_mux import sdram_pkg::*; ();

    // SDRAM accesses of all five tests and worst case cycles of one
    localparam int N_ACCESSES    = 35;
    localparam int ACCESS_CYCLES = 16;
    localparam int LIMIT         = 10 + 2 * N_ACCESSES * ACCESS_CYCLES;

    logic                 VB = 0;
    logic                 arst_n = 0;
    logic                 rom_cs = 0;
    logic                 gfx_cs = 0;
    logic                 adpcm_cs = 0;
    logic                 snd_cs = 0;
    logic                 ram_sel = 0;
    logic                 vram_sel = 0;
    logic                 ram_rnw = 1;
    logic [1:0]           ram_dsn = 2'b11;
    half_t                ram_din = '0;
    logic [`ROM_AW-1:0]   rom_addr = '0;
    logic [`RAM_AW-1:0]   ram_addr = '0;
    logic [`GFX_AW-1:0]   gfx_addr = '0;
    logic [`ADPCM_AW-1:0] adpcm_addr = '0;
    logic [`SND_AW-1:0]   snd_addr = '0;
    half_t                rom_data;
    half_t                ram_data;
    gfx_word_t            gfx_data;
    byte_t                adpcm_data;
    byte_t                snd_data;
    logic                 rom_ok;
    logic                 ram_ok;
    logic                 gfx_ok;
    logic                 adpcm_ok;
    logic                 snd_ok;
    logic                 sdram_req;
    logic                 sdram_rnw;
    logic                 sdram_ack;
    logic                 data_rdy;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic [1:0]           sdram_bank;
    logic [1:0]           sdram_wrmask;
    half_t                data_write;
    sdram_word_t          data_read;

    half_t                shadow [logic [23:0]];
    logic [31:0]          rng = 32'h5cf4;
    int                   errors = 0;
    int                   failed_tests = 0;
    int                   n_tests = 0;
    int                   req_count = 0;
    int                   cycles = 0;
    logic                 req_q = 0;

    always #10 VB = ~VB;

    sdram_mux_top dut_i (.*);
    sdram_model u_mem (.*);

    // Count issued SDRAM accesses and guard against a hang
    always @(posedge VB) begin
        req_q <= sdram_req;
        if (sdram_req && !req_q) req_count <= req_count + 1;
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles, a client never got ok", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected memory word from the write shadow or the fill pattern
    function automatic half_t ref_word(input logic [1:0] bank, input logic [21:0] a);
        logic [31:0] h;
        if (shadow.exists({bank, a})) return shadow[{bank, a}];
        h = {8'd0, bank, a} * 32'h9e37_79b1;
        return h[31:16] ^ h[15:0];
    endfunction

    task automatic check_half(input string name, input half_t got, input half_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_gfx(input string name, input gfx_word_t got, input gfx_word_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic rom_read(input logic [`ROM_AW-1:0] a);
        half_t exp;
        exp = ref_word(`BANK_CPU, 22'(a));
        @(posedge VB);
        rom_cs   <= 1;
        rom_addr <= a;
        do @(negedge VB); while (!rom_ok);
        check_half("rom_data", rom_data, exp);
        @(posedge VB);
        rom_cs <= 0;
    endtask

    task automatic gfx_read(input logic [`GFX_AW-1:0] a);
        gfx_word_t exp;
        exp = {ref_word(`BANK_GFX, `GFX_OFFSET + a + 22'd1),
               ref_word(`BANK_GFX, `GFX_OFFSET + a)};
        @(posedge VB);
        gfx_cs   <= 1;
        gfx_addr <= a;
        do @(negedge VB); while (!gfx_ok);
        check_gfx("gfx_data", gfx_data, exp);
        @(posedge VB);
        gfx_cs <= 0;
    endtask

    task automatic snd_read(input logic [`SND_AW-1:0] a);
        half_t w;
        w = ref_word(`BANK_SND, `SOUND_OFFSET + 22'(a >> 1));
        @(posedge VB);
        snd_cs   <= 1;
        snd_addr <= a;
        do @(negedge VB); while (!snd_ok);
        check_byte("snd_data", snd_data, a[0] ? w[15:8] : w[7:0]);
        @(posedge VB);
        snd_cs <= 0;
    endtask

    task automatic adpcm_read(input logic [`ADPCM_AW-1:0] a);
        half_t w;
        w = ref_word(`BANK_SND, `ADPCM_OFFSET + 22'(a >> 1));
        @(posedge VB);
        adpcm_cs   <= 1;
        adpcm_addr <= a;
        do @(negedge VB); while (!adpcm_ok);
        check_byte("adpcm_data", adpcm_data, a[0] ? w[15:8] : w[7:0]);
        @(posedge VB);
        adpcm_cs <= 0;
    endtask

    // Read when rnw is set and otherwise write d under the active-low byte mask
    task automatic ram_access(input logic vsel, input logic [`RAM_AW-1:0] a, input logic rnw,
                              input half_t d, input logic [1:0] dsn);
        logic [21:0] wa;
        half_t cur;
        wa  = (vsel ? `VRAM_OFFSET : `RAM_OFFSET) + 22'(a);
        cur = ref_word(`BANK_SND, wa);
        if (!dsn[0]) cur[7:0] = d[7:0];
        if (!dsn[1]) cur[15:8] = d[15:8];
        @(posedge VB);
        ram_sel  <= !vsel;
        vram_sel <= vsel;
        ram_addr <= a;
        ram_rnw  <= rnw;
        ram_din  <= d;
        ram_dsn  <= dsn;
        do @(negedge VB); while (!ram_ok);
        if (rnw) check_half("ram_data", ram_data, cur);
        else shadow[{`BANK_SND, wa}] = cur;
        @(posedge VB);
        ram_sel  <= 0;
        vram_sel <= 0;
        ram_rnw  <= 1;
        ram_dsn  <= 2'b11;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (errors != errs_before) failed_tests++;
        $display("test %0d %s: %s", n_tests, name, errors == errs_before ? "ok" : "errors");
    endtask

    initial begin
        int e;
        int reqs;
        logic [21:0] first_addr;
        logic [1:0] first_bank;
        repeat (10) @(posedge VB);
        arst_n <= 1;
        e = errors;
        repeat (8) begin
            rng = lcg(rng);
            rom_read(rng[30:10]);
        end
        finish_test("rom reads", e);
        e = errors;
        repeat (4) begin
            rng = lcg(rng);
            gfx_read(rng[31:10]);
        end
        reqs = req_count;
        gfx_read(rng[31:10]);
        if (req_count != reqs) begin
            $display("Cache hit on gfx raised an SDRAM request");
            errors++;
        end
        finish_test("gfx reads and hit", e);
        e = errors;
        repeat (2) begin
            rng = lcg(rng);
            snd_read({rng[23:9], 1'b0});
            snd_read({rng[23:9], 1'b1});
            adpcm_read({rng[25:9], 1'b0});
            adpcm_read({rng[25:9], 1'b1});
        end
        finish_test("byte reads", e);
        e = errors;
        ram_access(0, 17'h0123, 0, 16'hbeef, 2'b00);
        ram_access(0, 17'h0123, 1, 16'h0, 2'b11);
        ram_access(0, 17'h0123, 0, 16'h5a5a, 2'b10);
        ram_access(0, 17'h0123, 1, 16'h0, 2'b11);
        ram_access(0, 17'h0456, 0, 16'hc3c3, 2'b01);
        ram_access(0, 17'h0456, 1, 16'h0, 2'b11);
        ram_access(1, 17'h0123, 0, 16'h1234, 2'b00);
        ram_access(1, 17'h0123, 1, 16'h0, 2'b11);
        ram_access(0, 17'h0123, 1, 16'h0, 2'b11);
        finish_test("ram writes", e);
        e = errors;
        rng = lcg(rng);
        fork
            rom_read(rng[28:8]);
            ram_access(1, 17'h0777, 1, 16'h0, 2'b11);
            gfx_read(rng[25:4]);
            adpcm_read(rng[20:3]);
            snd_read(rng[18:3]);
            begin
                do @(negedge VB); while (!sdram_req);
                first_addr = sdram_addr;
                first_bank = sdram_bank;
            end
        join
        if (first_addr !== 22'(rng[28:8]) || first_bank !== `BANK_CPU) begin
            $display("First access of the burst did not come from the rom slot");
            errors++;
        end
        finish_test("all slots at once", e);
        $display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/sdram_pkg.sv
design/slot_cache.sv
design/slot_arbiter.sv
design/sdram_mux_top.sv
bench/sdram_model.sv
bench/tb_sdram_mux.sv

// File: Bender.yml
package:
  name: sdram_mux

sources:
  - include_dirs:
      - design
    files:
      - design/sdram_pkg.sv
      - design/slot_cache.sv
      - design/slot_arbiter.sv
      - design/sdram_mux_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/sdram_model.sv
      - bench/tb_sdram_mux.sv
